// File: battle_defs.svh
`ifndef battleDefsSvh
`define battleDefsSvh

////////////////////////////////////////
// raster timing, 640x480 at one pixel per clk
////////////////////////////////////////
`define HVisible    640                 // visible columns
`define HFront      16                  // front porch after the visible part
`define HSyncLen    96                  // hsync pulse width
`define HBack       48                  // back porch before the next line
`define VVisible    480                 // visible lines
`define VFront      10
`define VSyncLen    2
`define VBack       33

// totals, 800 by 525
`define HTotal      (`HVisible + `HFront + `HSyncLen + `HBack)
`define VTotal      (`VVisible + `VFront + `VSyncLen + `VBack)

////////////////////////////////////////
// board geometry
////////////////////////////////////////
`define TileShift   4                   // 16x16 pixels per tile
`define BoardTiles  16                  // 16x16 tiles per board
`define BoardPix    (`BoardTiles << `TileShift) // board edge in pixels
`define UsBoardX0   0                   // left edge of our own board
`define ThemBoardX0 256                 // left edge of the opponent board

////////////////////////////////////////
// tile codes, 2 bits
////////////////////////////////////////
`define TileEmpty   2'd0
`define TileShip    2'd1
`define TileHit     2'd2
`define TileMiss    2'd3

// colours as 4:4:4 rgb
`define ColorEmpty  12'h028             // open water
`define ColorShip   12'h888             // grey hull
`define ColorHit    12'hF00
`define ColorMiss   12'hFFF
`define ColorGhost  12'h0F0             // placement preview
`define ColorBack   12'h222             // active video off the boards
`define ColorBlank  12'h000             // must stay black in blanking

`define MaxShipLen  5                   // carrier

`endif

// File: battlePkg.sv
package battlePkg;

    ////////////////////////////////////////
    // plain vector types
    ////////////////////////////////////////
    typedef logic [9:0]  pixelCoord_t;  // pixel row or column, up to 799
    typedef logic [3:0]  tileIdx_t;     // tile row or column inside one board
    typedef logic [1:0]  tileCode_t;    // empty / ship / hit / miss
    typedef logic [11:0] rgb_t;         // {r, g, b} at 4 bits each

    ////////////////////////////////////////
    // raster position, one per pixel clock
    ////////////////////////////////////////
    typedef struct packed {
        pixelCoord_t x;                 // column counter
        pixelCoord_t y;                 // line counter
        logic        active;            // inside the 640x480 window
        logic        hsync;             // active low
        logic        vsync;             // active low
    } rasterPos_t;

    // tile write request from outside
    typedef struct packed {
        logic      board;               // 0 us, 1 them
        tileIdx_t  row;
        tileIdx_t  col;
        tileCode_t code;
    } tileWrite_t;

    // ghost ship settings, sampled once per frame
    typedef struct packed {
        logic       enable;
        tileIdx_t   row;                // cursor row on the us board
        tileIdx_t   col;                // cursor column
        logic       vertical;           // 0 runs right, 1 runs down
        logic [2:0] len;                // ship length in tiles
    } ghostCfg_t;

endpackage

// File: displayTiming.sv
`timescale 1ns/10ps
`include "battle_defs.svh"

module displayTiming (
    input  logic                  clk,
    input  logic                  rstN,
    output battlePkg::rasterPos_t pos
);
    import battlePkg::*;

    pixelCoord_t hCnt;                  // column, wraps at HTotal
    pixelCoord_t vCnt;                  // line, wraps at VTotal
    logic        lineEnd;
    logic        frameEnd;

    assign lineEnd  = (hCnt == pixelCoord_t'(`HTotal - 1));
    assign frameEnd = (vCnt == pixelCoord_t'(`VTotal - 1));

    ////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hCnt <= '0;
            vCnt <= '0;
        end else begin
            if (lineEnd) begin
                hCnt <= '0;
                vCnt <= frameEnd ? '0 : vCnt + 1'b1; // next line or back to the top
            end else begin
                hCnt <= hCnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // flags straight from the counters
    ////////////////////////////////////////
    assign pos.x      = hCnt;
    assign pos.y      = vCnt;
    assign pos.active = (hCnt < `HVisible) && (vCnt < `VVisible);

    // sync pulses sit after the front porch, low while inside
    assign pos.hsync = !((hCnt >= (`HVisible + `HFront)) &&
                         (hCnt <  (`HVisible + `HFront + `HSyncLen)));
    assign pos.vsync = !((vCnt >= (`VVisible + `VFront)) &&
                         (vCnt <  (`VVisible + `VFront + `VSyncLen)));

    // counters never leave the 800x525 frame
    assert property (@(posedge clk) disable iff (!rstN)
        (hCnt < `HTotal) && (vCnt < `VTotal))
        else $error("raster counter out of range h=%0d v=%0d", hCnt, vCnt);

endmodule

// File: tileMemory.sv
`timescale 1ns/10ps
`include "battle_defs.svh"

module tileMemory (
    input  logic                 clk,
    input  logic                 we,
    input  logic [7:0]           wAddr,     // {tile row, tile col}
    input  battlePkg::tileCode_t wData,
    input  logic [7:0]           rAddr,
    output battlePkg::tileCode_t rData
);
    import battlePkg::*;

    localparam int Depth = `BoardTiles * `BoardTiles; // 256 tiles

    ////////////////////////////////////////
    // tile store
    ////////////////////////////////////////
    tileCode_t mem [Depth];

    // write lands on the accepting edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wAddr] <= wData;
        end
    end

    // synchronous read, one cycle of latency
    // a read of the address being written returns the old code
    always_ff @(posedge clk) begin
        rData <= mem[rAddr];
    end

endmodule

// File: boardRenderer.sv
`timescale 1ns/10ps
`include "battle_defs.svh"

module boardRenderer (
    input  logic                  clk,
    input  logic                  rstN,
    input  battlePkg::rasterPos_t pos,
    input  battlePkg::tileWrite_t tileWr,
    input  logic                  tileWrValid,
    output logic                  tileWrReady,
    output battlePkg::rasterPos_t posD,
    output logic                  onUs,
    output logic                  onThem,
    output battlePkg::tileCode_t  tileCode
);
    import battlePkg::*;

    pixelCoord_t usRelX;                // x relative to each board edge
    pixelCoord_t themRelX;
    logic        inUs;
    logic        inThem;
    tileIdx_t    tileRow;
    logic [7:0]  usRAddr;
    logic [7:0]  themRAddr;
    logic [7:0]  wAddr;
    logic        wrAccept;
    tileCode_t   usData;
    tileCode_t   themData;

    ////////////////////////////////////////
    // stage 0, which board and which tile
    ////////////////////////////////////////
    assign usRelX   = pos.x - pixelCoord_t'(`UsBoardX0);   // wraps high left of the board
    assign themRelX = pos.x - pixelCoord_t'(`ThemBoardX0);
    assign inUs     = pos.active && (pos.y < `BoardPix) && (usRelX < `BoardPix);
    assign inThem   = pos.active && (pos.y < `BoardPix) && (themRelX < `BoardPix);

    assign tileRow   = tileIdx_t'(pos.y >> `TileShift);
    assign usRAddr   = {tileRow, tileIdx_t'(usRelX >> `TileShift)};
    assign themRAddr = {tileRow, tileIdx_t'(themRelX >> `TileShift)};

    // write port, only open outside active video
    // counters sit at the origin during reset so ready is low there too
    assign tileWrReady = !pos.active;
    assign wrAccept    = tileWrValid && tileWrReady;
    assign wAddr       = {tileWr.row, tileWr.col};

    tileMemory usMem_i (
        .clk   (clk),
        .we    (wrAccept && !tileWr.board),
        .wAddr (wAddr),
        .wData (tileWr.code),
        .rAddr (usRAddr),
        .rData (usData)
    );

    tileMemory themMem_i (
        .clk   (clk),
        .we    (wrAccept && tileWr.board),
        .wAddr (wAddr),
        .wData (tileWr.code),
        .rAddr (themRAddr),
        .rData (themData)
    );

    ////////////////////////////////////////
    // stage 1, line up with the read data
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            onUs   <= 1'b0;
            onThem <= 1'b0;
        end else begin
            onUs   <= inUs;
            onThem <= inThem;
        end
    end

    always_ff @(posedge clk) begin
        posD <= pos;                    // stage-1 copy of the raster position
    end

    assign tileCode = onUs   ? usData   :
                      onThem ? themData : `TileEmpty;

    // an accepted write always falls outside the visible window
    assert property (@(posedge clk) disable iff (!rstN)
        wrAccept |-> (pos.x >= `HVisible) || (pos.y >= `VVisible))
        else $error("tile write accepted during active video");

endmodule

// File: ghostShip.sv
`timescale 1ns/10ps
`include "battle_defs.svh"

module ghostShip (
    input  logic                  clk,
    input  logic                  rstN,
    input  battlePkg::rasterPos_t pos,
    input  battlePkg::ghostCfg_t  ghostCfg,
    output logic                  ghostHit
);
    import battlePkg::*;

    ghostCfg_t   cfgQ;                  // held for the whole frame
    ghostCfg_t   cfgCur;
    logic        atOrigin;
    pixelCoord_t relX;
    logic        inUs;
    tileIdx_t    tileRow;
    tileIdx_t    tileCol;
    logic [4:0]  runEnd;                // one past the last tile, may exceed 15
    logic        hitH;
    logic        hitV;

    ////////////////////////////////////////
    // frame latch
    ////////////////////////////////////////
    assign atOrigin = (pos.x == '0) && (pos.y == '0);
    assign cfgCur   = atOrigin ? ghostCfg : cfgQ; // origin pixel already sees the new cfg

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cfgQ <= '0;                 // ghost off
        end else if (atOrigin) begin
            cfgQ <= ghostCfg;
        end
    end

    ////////////////////////////////////////
    // span test on the us board
    ////////////////////////////////////////
    assign relX    = pos.x - pixelCoord_t'(`UsBoardX0);
    assign inUs    = pos.active && (pos.y < `BoardPix) && (relX < `BoardPix);
    assign tileRow = tileIdx_t'(pos.y >> `TileShift);
    assign tileCol = tileIdx_t'(relX >> `TileShift);

    // run starts at the cursor, clipped by the board edge since tiles stop at 15
    assign runEnd = (cfgCur.vertical ? {1'b0, cfgCur.row} : {1'b0, cfgCur.col})
                    + {2'b00, cfgCur.len};

    assign hitH = !cfgCur.vertical && (tileRow == cfgCur.row) &&
                  (tileCol >= cfgCur.col) && ({1'b0, tileCol} < runEnd);
    assign hitV = cfgCur.vertical && (tileCol == cfgCur.col) &&
                  (tileRow >= cfgCur.row) && ({1'b0, tileRow} < runEnd);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ghostHit <= 1'b0;
        end else begin
            ghostHit <= cfgCur.enable && inUs && (hitH || hitV);
        end
    end

    // an enabled ghost always has a real ship length
    assert property (@(posedge clk) disable iff (!rstN)
        cfgQ.enable |-> (cfgQ.len >= 3'd1) && (cfgQ.len <= `MaxShipLen))
        else $error("ghost length %0d out of range", cfgQ.len);

endmodule

// File: pixelMixer.sv
`timescale 1ns/10ps
`include "battle_defs.svh"

module pixelMixer (
    input  logic                  clk,
    input  logic                  rstN,
    input  battlePkg::rasterPos_t posD,
    input  logic                  onUs,
    input  logic                  onThem,
    input  logic                  ghostHit,
    input  battlePkg::tileCode_t  tileCode,
    output battlePkg::rgb_t       rgb,
    output logic                  hsync,
    output logic                  vsync
);
    import battlePkg::*;

    rgb_t tileColor;
    rgb_t pixColor;

    ////////////////////////////////////////
    // colour pick
    ////////////////////////////////////////
    always_comb begin
        case (tileCode)
            `TileShip: tileColor = `ColorShip;
            `TileHit:  tileColor = `ColorHit;
            `TileMiss: tileColor = `ColorMiss;
            default:   tileColor = `ColorEmpty;
        endcase
    end

    // blanking beats ghost beats tiles beats background
    always_comb begin
        if (!posD.active) begin
            pixColor = `ColorBlank;
        end else if (ghostHit) begin
            pixColor = `ColorGhost;
        end else if (onUs || onThem) begin
            pixColor = tileColor;
        end else begin
            pixColor = `ColorBack;
        end
    end

    ////////////////////////////////////////
    // output register, colour and syncs together
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rgb   <= `ColorBlank;
            hsync <= 1'b1;              // syncs idle high
            vsync <= 1'b1;
        end else begin
            rgb   <= pixColor;
            hsync <= posD.hsync;
            vsync <= posD.vsync;
        end
    end

endmodule

// File: battleVideoTop.sv
`timescale 1ns/10ps

module battleVideoTop (
    input  logic                  clk,
    input  logic                  rstN,
    input  battlePkg::tileWrite_t tileWr,
    input  logic                  tileWrValid,
    output logic                  tileWrReady,
    input  battlePkg::ghostCfg_t  ghostCfg,
    output battlePkg::rgb_t       rgb,
    output logic                  hsync,
    output logic                  vsync
);
    import battlePkg::*;

    rasterPos_t pos;                    // stage 0
    rasterPos_t posD;                   // stage 1
    tileCode_t  tileCode;
    logic       onUs;
    logic       onThem;
    logic       ghostHit;

    ////////////////////////////////////////
    // stage 0, raster
    ////////////////////////////////////////
    displayTiming timing_i (
        .clk  (clk),
        .rstN (rstN),
        .pos  (pos)
    );

    ////////////////////////////////////////
    // stage 1, tiles and ghost
    ////////////////////////////////////////
    boardRenderer render_i (
        .clk         (clk),
        .rstN        (rstN),
        .pos         (pos),
        .tileWr      (tileWr),
        .tileWrValid (tileWrValid),
        .tileWrReady (tileWrReady),
        .posD        (posD),
        .onUs        (onUs),
        .onThem      (onThem),
        .tileCode    (tileCode)
    );

    ghostShip ghost_i (
        .clk      (clk),
        .rstN     (rstN),
        .pos      (pos),
        .ghostCfg (ghostCfg),
        .ghostHit (ghostHit)
    );

    // stage 2, registered colour out
    pixelMixer mixer_i (
        .clk      (clk),
        .rstN     (rstN),
        .posD     (posD),
        .onUs     (onUs),
        .onThem   (onThem),
        .ghostHit (ghostHit),
        .tileCode (tileCode),
        .rgb      (rgb),
        .hsync    (hsync),
        .vsync    (vsync)
    );

endmodule

// File: tbBattleVideo.sv
`timescale 1ns/10ps
`include "battle_defs.svh"

module tbBattleVideo;
    import battlePkg::*;

    localparam int StimDepth = 64;              // room for the stim records
    localparam int FrameLen  = `HTotal * `VTotal; // cycles per frame, one pixel each
    localparam int HSyncBeg  = `HVisible + `HFront;
    localparam int VSyncBeg  = `VVisible + `VFront;

    // record kinds in the stim file
    localparam logic [3:0] KindWrite = 4'h1;    // single tile write
    localparam logic [3:0] KindFill  = 4'h2;    // whole board, one code
    localparam logic [3:0] KindGhost = 4'h3;    // ghost setting for the next frame
    localparam logic [3:0] KindCheck = 4'h4;    // expected rgb at x, y

    logic       clk = 1'b0;
    logic       rstN;
    tileWrite_t tileWr;
    logic       tileWrValid;
    logic       tileWrReady;
    ghostCfg_t  ghostCfg;
    rgb_t       rgb;
    logic       hsync;
    logic       vsync;

    logic [43:0] stim [StimDepth];              // {kind, x, y, value}
    int          cyc = 0;                       // cycles since reset release
    int          cycleLimit = 0;
    int          leadX = 0;                     // position the DUT timing shows now
    int          leadY = 0;
    int          outX = 0;                      // position now at the rgb output
    int          outY = 0;

    always #4 clk = ~clk;                       // 8 ns period

    battleVideoTop dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .tileWr      (tileWr),
        .tileWrValid (tileWrValid),
        .tileWrReady (tileWrReady),
        .ghostCfg    (ghostCfg),
        .rgb         (rgb),
        .hsync       (hsync),
        .vsync       (vsync)
    );

    ////////////////////////////////////////
    // reference raster counters
    ////////////////////////////////////////
    always @(posedge clk) begin
        if (!rstN) begin
            cyc   <= 0;
            leadX <= 0;
            leadY <= 0;
            outX  <= 0;
            outY  <= 0;
        end else begin
            cyc <= cyc + 1;
            if (leadX == `HTotal - 1) begin
                leadX <= 0;
                leadY <= (leadY == `VTotal - 1) ? 0 : leadY + 1;
            end else begin
                leadX <= leadX + 1;
            end
            if (cyc >= 2) begin                 // output trails the timing by two stages
                if (outX == `HTotal - 1) begin
                    outX <= 0;
                    outY <= (outY == `VTotal - 1) ? 0 : outY + 1;
                end else begin
                    outX <= outX + 1;
                end
            end
        end
    end

    function automatic logic isVisible(input int x, input int y);
        return (x < `HVisible) && (y < `VVisible);
    endfunction

    task automatic stopOnError();
        $display("Result: FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkValue(input string sigName, input logic [11:0] got,
                              input logic [11:0] expVal);
        assert (got === expVal) else begin
            $display("Mismatch at %0d ns: %s got %h expected %h (raster x=%0d y=%0d)",
                     $time, sigName, got, expVal, outX, outY);
            stopOnError();
        end
    endtask

    // every cycle, syncs and blanking against the reference counters
    always @(negedge clk) begin
        if (rstN) begin
            assert (cyc < cycleLimit) else begin
                $display("Timeout: stimulus not finished after %0d cycles", cycleLimit);
                stopOnError();
            end
            if (isVisible(leadX, leadY)) begin
                checkValue("tileWrReady", tileWrReady, 1'b0); // port shut in active video
            end
            if (cyc >= 2) begin
                checkValue("hsync", hsync,
                           !((outX >= HSyncBeg) && (outX < HSyncBeg + `HSyncLen)));
                checkValue("vsync", vsync,
                           !((outY >= VSyncBeg) && (outY < VSyncBeg + `VSyncLen)));
                if (!isVisible(outX, outY)) begin
                    checkValue("rgb", rgb, `ColorBlank);
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////
    task automatic writeTile(input tileWrite_t w);
        @(posedge clk);
        tileWr      <= w;
        tileWrValid <= 1'b1;
        do begin
            @(negedge clk);                     // held until blanking opens the port
        end while (!tileWrReady);
        @(posedge clk);                         // transfer edge
        tileWrValid <= 1'b0;
    endtask

    task automatic fillBoard(input logic board, input tileCode_t code);
        tileWrite_t w;
        w.board = board;
        w.code  = code;
        for (int r = 0; r < `BoardTiles; r++) begin
            for (int c = 0; c < `BoardTiles; c++) begin
                w.row = tileIdx_t'(r);
                w.col = tileIdx_t'(c);
                writeTile(w);
            end
        end
    endtask

    // new setting lands in vertical blanking, latched at the next origin
    task automatic setGhost(input ghostCfg_t cfg);
        do begin
            @(negedge clk);
        end while (leadY < `VVisible);
        @(posedge clk);
        ghostCfg <= cfg;
    endtask

    task automatic checkPixel(input int x, input int y, input rgb_t expRgb);
        do begin
            @(negedge clk);
        end while (!((cyc >= 2) && (outX == x) && (outY == y)));
        checkValue("rgb", rgb, expRgb);
    endtask

    ////////////////////////////////////////
    // main flow
    ////////////////////////////////////////
    initial begin : mainFlow
        int          frames;
        int          lastLin;
        int          lin;
        int          idx;
        logic [43:0] rec;
        tileWrite_t  wr;
        ghostCfg_t   gc;

        rstN        = 1'b0;
        tileWr      = '0;
        tileWrValid = 1'b0;
        ghostCfg    = '0;
        for (idx = 0; idx < StimDepth; idx++) begin
            stim[idx] = '0;                     // kind 0 ends the list
        end
        $readmemh("battle_stim.txt", stim);

        // frames the records need, setup frame included
        frames  = 1;
        lastLin = -1;
        for (idx = 0; idx < StimDepth; idx++) begin
            assert (stim[idx][43:40] <= KindCheck) else begin
                $display("Stim record %0d has an unknown kind %h", idx, stim[idx][43:40]);
                stopOnError();
            end
            if (stim[idx][43:40] == KindGhost) begin
                frames++;
                lastLin = -1;
            end else if (stim[idx][43:40] == KindCheck) begin
                lin = stim[idx][27:16] * `HTotal + stim[idx][39:28];
                if (lin <= lastLin) begin
                    frames++;                   // behind the previous check, next frame
                end
                lastLin = lin;
            end
        end
        cycleLimit = (frames + 1) * FrameLen;

        repeat (4) @(posedge clk);
        @(negedge clk);                         // outputs settled under reset
        checkValue("rgb", rgb, `ColorBlank);
        checkValue("hsync", hsync, 1'b1);
        checkValue("vsync", vsync, 1'b1);
        checkValue("tileWrReady", tileWrReady, 1'b0);
        @(posedge clk);
        rstN <= 1'b1;                           // fifth edge still sees reset

        idx = 0;
        while ((idx < StimDepth) && (stim[idx][43:40] != 4'h0)) begin
            rec = stim[idx];
            wr  = rec[10:0];
            gc  = rec[12:0];
            case (rec[43:40])
                KindWrite: writeTile(wr);
                KindFill:  fillBoard(wr.board, wr.code);
                KindGhost: setGhost(gc);
                KindCheck: checkPixel(rec[39:28], rec[27:16], rec[11:0]);
                default:   ;
            endcase
            idx++;
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: battle_stim.txt
// kind_x_y_value in hex: kind 1 tile write, 2 board fill, 3 ghost setting, 4 pixel check
// write and fill values are tileWrite_t, ghost values ghostCfg_t, check values the rgb
2_000_000_0000 // fill us board empty
2_000_000_0400 // fill them board empty
1_000_000_008D // us r2 c3 ship
1_000_000_0142 // us r5 c0 hit
1_000_000_03FF // us r15 c15 miss
1_000_000_0401 // them r0 c0 ship
1_000_000_05E6 // them r7 c9 hit
1_000_000_07FF // them r15 c15 miss
3_000_000_0000 // ghost off for frame 1
4_000_000_0028 // us corner, empty
4_100_000_0888 // them r0 c0 ship
4_200_000_0222 // right of both boards
4_280_000_0000 // horizontal blanking
4_030_020_0888 // ship tile top left
4_03F_02F_0888 // ship tile bottom right
1_000_000_0291 // us r10 c4 ship, issued in active video
4_00F_05F_0F00 // us hit
4_19F_07F_0F00 // them hit
4_04F_0AF_0888 // tile written in the same frame
4_0FF_0FF_0FFF // us miss
4_1FF_0FF_0FFF // them miss
4_064_100_0222 // below the boards
3_000_000_1223 // ghost r2 c2 across, length 3
4_020_020_00F0 // run start
4_030_028_00F0 // ghost over the ship tile
4_050_02F_0028 // one past the run
3_000_000_1DFC // ghost r13 c15 down, length 4
4_0F0_0CF_0028 // row above the run
4_0F0_0D0_00F0 // run start
4_100_0D0_0028 // them board left of it stays clear
4_0FF_0FF_00F0 // ghost over the miss tile
4_0F0_100_0222 // clipped at the board bottom

// File: filelist.f
+incdir+.
battlePkg.sv
displayTiming.sv
tileMemory.sv
boardRenderer.sv
ghostShip.sv
pixelMixer.sv
battleVideoTop.sv
tbBattleVideo.sv

// File: Bender.yml
package:
  name: battle_video

export_include_dirs:
  - .

sources:
  - battlePkg.sv
  - displayTiming.sv
  - tileMemory.sv
  - boardRenderer.sv
  - ghostShip.sv
  - pixelMixer.sv
  - battleVideoTop.sv
  - target: test
    files:
      - tbBattleVideo.sv
